// ==== matmul_top.f ====
verilog/matmul_csr_pkg.sv
verilog/matmul_data_pkg.sv
verilog/apb_csr_slave.sv
verilog/operand_fetch.sv
verilog/mac_unit.sv
verilog/result_writer.sv
verilog/scratch_ram.sv
verilog/matmul_top.sv
tb/tb_clock_gen.sv
tb/matmul_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f matmul_top.f \
    --top-module matmul_tb \
    -o sim_matmul

# The log decides the result, not the exit code of tee
./obj_dir/sim_matmul | tee sim.log

if grep -q "TEST PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== tb/matmul_tb.sv ====
`timescale 1ns/1ps

module matmul_tb;
    import matmul_csr_pkg::*;
    import matmul_data_pkg::*;

    localparam int DIM       = 4;
    localparam int NUM_TESTS = 5;
    localparam int LIMIT     = 4 * (NUM_TESTS * (DIM * DIM * DIM + 2000));

    // Operand and result placement with non-unit strides
    localparam int BASE_A   = 'h10;
    localparam int BASE_B   = 'h40;
    localparam int BASE_C   = 'h80;
    localparam int STRIDE_A = 6;
    localparam int STRIDE_B = 5;
    localparam int STRIDE_C = 7;

    logic                  PCLK;
    logic                  PRESETn;
    logic [APB_ADDR_W-1:0] PADDR;
    logic                  PWRITE;
    logic                  PSEL;
    logic                  PENABLE;
    logic [APB_DATA_W-1:0] PWDATA;
    logic [APB_DATA_W-1:0] PRDATA;
    logic                  PREADY;

    integer            seed;
    int                cycles = 0;
    logic [WORD_W-1:0] a_mat [DIM][DIM];
    logic [WORD_W-1:0] b_mat [DIM][DIM];
    elem16_t           exp_c [DIM][DIM];
    logic [WORD_W-1:0] shadow [256];

    tb_clock_gen u_clk (
        .PCLK    (PCLK),
        .PRESETn (PRESETn)
    );

    matmul_top #(
        .DIM (DIM)
    ) u_dut (
        .PCLK    (PCLK),
        .PRESETn (PRESETn),
        .PADDR   (PADDR),
        .PWRITE  (PWRITE),
        .PSEL    (PSEL),
        .PENABLE (PENABLE),
        .PWDATA  (PWDATA),
        .PRDATA  (PRDATA),
        .PREADY  (PREADY)
    );

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    always @(posedge PCLK) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", LIMIT);
            abort_run();
        end
    end

    // Expected C with 16-bit clipping
    // Returns 1 when any element clipped
    function automatic logic ref_matmul(input logic int8_mode);
        longint sum;
        logic   sat;
        sat = 1'b0;
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                sum = 0;
                for (int k = 0; k < DIM; k++) begin
                    if (int8_mode) begin
                        // High lanes multiply together and so do low lanes
                        sum += longint'($signed(a_mat[i][k][15:8]))
                             * longint'($signed(b_mat[k][j][15:8]));
                        sum += longint'($signed(a_mat[i][k][7:0]))
                             * longint'($signed(b_mat[k][j][7:0]));
                    end else begin
                        sum += longint'($signed(a_mat[i][k])) * longint'($signed(b_mat[k][j]));
                    end
                end
                if (sum > 32767) begin
                    exp_c[i][j] = 16'sh7fff;
                    sat = 1'b1;
                end else if (sum < -32768) begin
                    exp_c[i][j] = 16'sh8000;
                    sat = 1'b1;
                end else begin
                    exp_c[i][j] = elem16_t'(sum);
                end
            end
        end
        return sat;
    endfunction

    function automatic logic [APB_ADDR_W-1:0] win_addr(input logic [AWIDTH-1:0] a);
        return {1'b1, a};
    endfunction

    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr,
                             input logic [APB_DATA_W-1:0] data);
        @(posedge PCLK);
        PSEL    <= 1'b1;
        PENABLE <= 1'b0;
        PWRITE  <= 1'b1;
        PADDR   <= addr;
        PWDATA  <= data;
        @(posedge PCLK);
        PENABLE <= 1'b1;
        @(posedge PCLK);
        PSEL    <= 1'b0;
        PENABLE <= 1'b0;
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr,
                            output logic [APB_DATA_W-1:0] data);
        @(posedge PCLK);
        PSEL    <= 1'b1;
        PENABLE <= 1'b0;
        PWRITE  <= 1'b0;
        PADDR   <= addr;
        @(posedge PCLK);
        PENABLE <= 1'b1;
        // PRDATA is settled mid access phase
        @(negedge PCLK);
        data = PRDATA;
        if (PREADY !== 1'b1) begin
            $display("PREADY was not high during a read access phase");
            abort_run();
        end
        @(posedge PCLK);
        PSEL    <= 1'b0;
        PENABLE <= 1'b0;
    endtask

    task automatic check_word(input string name, input logic [APB_DATA_W-1:0] expected,
                              input logic [APB_DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_elem(input string name, input elem16_t expected,
                              input elem16_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    // STATUS holds done in bit 0, flags above it and busy on top
    task automatic check_status(input string name, input logic exp_busy,
                                input logic [FLAG_W-1:0] exp_flags,
                                input logic exp_done,
                                input logic [APB_DATA_W-1:0] status);
        logic [APB_DATA_W-1:0] exp_word;
        exp_word = APB_DATA_W'({exp_busy, exp_flags, exp_done});
        if (status !== exp_word) begin
            $display("MISMATCH %s: expected busy/flags/done %b, actual %b",
                     name, exp_word[FLAG_W+1:0], status[FLAG_W+1:0]);
            abort_run();
        end
    endtask

    task automatic fill_int16();
        int v;
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                v = $random(seed) % 200;
                a_mat[r][c] = 16'(v);
                v = $random(seed) % 200;
                b_mat[r][c] = 16'(v);
            end
        end
    endtask

    task automatic fill_int8();
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                a_mat[r][c] = 16'($random(seed));
                b_mat[r][c] = 16'($random(seed));
            end
        end
    endtask

    task automatic load_operands();
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                apb_write(win_addr(AWIDTH'(BASE_A + r * STRIDE_A + c)),
                          APB_DATA_W'(a_mat[r][c]));
                apb_write(win_addr(AWIDTH'(BASE_B + r * STRIDE_B + c)),
                          APB_DATA_W'(b_mat[r][c]));
            end
        end
    endtask

    task automatic program_engine(input logic int8_mode);
        apb_write(ADDR_MAT_A, APB_DATA_W'(BASE_A));
        apb_write(ADDR_MAT_B, APB_DATA_W'(BASE_B));
        apb_write(ADDR_MAT_C, APB_DATA_W'(BASE_C));
        apb_write(ADDR_STRIDE_A, APB_DATA_W'(STRIDE_A));
        apb_write(ADDR_STRIDE_B, APB_DATA_W'(STRIDE_B));
        apb_write(ADDR_STRIDE_C, APB_DATA_W'(STRIDE_C));
        apb_write(ADDR_ELEM_INT8, APB_DATA_W'(int8_mode));
    endtask

    task automatic wait_done(output logic [APB_DATA_W-1:0] status);
        status = '0;
        while (!status[0]) begin
            apb_read(ADDR_STATUS, status);
        end
    endtask

    task automatic compare_c(input string name);
        logic [APB_DATA_W-1:0] rd;
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                apb_read(win_addr(AWIDTH'(BASE_C + i * STRIDE_C + j)), rd);
                check_elem($sformatf("%s C[%0d][%0d]", name, i, j), exp_c[i][j],
                           elem16_t'(rd[WORD_W-1:0]));
            end
        end
    endtask

    initial begin
        logic [APB_DATA_W-1:0] rd;
        logic [APB_DATA_W-1:0] val;
        logic [AWIDTH-1:0]     a;
        logic [AWIDTH-1:0]     addr_q [$];
        logic                  sat;

        PSEL    <= 1'b0;
        PENABLE <= 1'b0;
        PWRITE  <= 1'b0;
        PADDR   <= '0;
        PWDATA  <= '0;
        seed = 39;
        wait (PRESETn === 1'b1);
        @(posedge PCLK);

        // Register access
        apb_read(ADDR_STATUS, rd);
        check_word("registers STATUS after reset", '0, rd);
        for (int off = 1; off <= 6; off++) begin
            val = $random(seed);
            apb_write(APB_ADDR_W'(off), val);
            apb_read(APB_ADDR_W'(off), rd);
            check_word($sformatf("registers offset %0d", off), APB_DATA_W'(val[7:0]), rd);
        end
        apb_write(ADDR_ELEM_INT8, 32'hffff_fffe);
        apb_read(ADDR_ELEM_INT8, rd);
        check_word("registers ELEM_INT8 even", '0, rd);
        apb_write(ADDR_ELEM_INT8, 32'h0000_0003);
        apb_read(ADDR_ELEM_INT8, rd);
        check_word("registers ELEM_INT8 odd", 32'h1, rd);
        apb_read(APB_ADDR_W'(9), rd);
        check_word("registers unmapped 9", '0, rd);
        apb_read(APB_ADDR_W'('hff), rd);
        check_word("registers unmapped 0xff", '0, rd);

        // Memory window
        repeat (24) begin
            a   = AWIDTH'($random(seed));
            val = $random(seed);
            apb_write(win_addr(a), val);
            shadow[a] = val[WORD_W-1:0];
            addr_q.push_back(a);
        end
        foreach (addr_q[n]) begin
            apb_read(win_addr(addr_q[n]), rd);
            check_word($sformatf("window addr 0x%02h", addr_q[n]),
                       APB_DATA_W'(shadow[addr_q[n]]), rd);
        end

        // int16 multiply
        fill_int16();
        load_operands();
        program_engine(1'b0);
        sat = ref_matmul(1'b0);
        apb_write(ADDR_START, 32'h1);
        wait_done(rd);
        check_status("int16 STATUS", 1'b0, {1'b0, sat}, 1'b1, rd);
        compare_c("int16");

        // int8 multiply where rows 0 and 1 clip high and low
        fill_int8();
        for (int k = 0; k < DIM; k++) begin
            a_mat[0][k] = 16'h7f7f;
            a_mat[1][k] = 16'h8080;
            b_mat[k][0] = 16'h7f7f;
            b_mat[k][1] = 16'h7f7f;
        end
        load_operands();
        program_engine(1'b1);
        void'(ref_matmul(1'b1));
        apb_write(ADDR_START, 32'h1);
        wait_done(rd);
        check_status("int8 STATUS", 1'b0, 2'b01, 1'b1, rd);
        compare_c("int8");

        // Busy behavior
        fill_int16();
        a_mat[0][0] = 16'h0055;
        load_operands();
        program_engine(1'b0);
        sat = ref_matmul(1'b0);
        apb_write(ADDR_START, 32'h1);
        apb_write(ADDR_START, 32'h1);
        apb_read(win_addr(AWIDTH'(BASE_A)), rd);
        check_word("busy window read", '0, rd);
        // Still early in the run, no C word written yet
        apb_read(ADDR_STATUS, rd);
        check_status("busy STATUS running", 1'b1, 2'b10, 1'b0, rd);
        wait_done(rd);
        check_status("busy STATUS", 1'b0, {1'b1, sat}, 1'b1, rd);
        compare_c("busy");

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic PCLK,
    output logic PRESETn
);

    // 8 ns period
    initial begin
        PCLK = 1'b0;
        forever #4 PCLK = ~PCLK;
    end

    initial begin
        PRESETn = 1'b0;
        repeat (10) @(posedge PCLK);
        PRESETn <= 1'b1;
    end

endmodule

// ==== verilog/matmul_top.sv ====
`timescale 1ns/1ps

module matmul_top #(
    // Matrix size in words, int8 mode packs two K elements per word
    parameter int DIM = 4
) (
    input  logic                                  PCLK,
    input  logic                                  PRESETn,
    input  logic [matmul_csr_pkg::APB_ADDR_W-1:0] PADDR,
    input  logic                                  PWRITE,
    input  logic                                  PSEL,
    input  logic                                  PENABLE,
    input  logic [matmul_csr_pkg::APB_DATA_W-1:0] PWDATA,
    output logic [matmul_csr_pkg::APB_DATA_W-1:0] PRDATA,
    output logic                                  PREADY
);
    import matmul_csr_pkg::*;
    import matmul_data_pkg::*;

    logic                start;
    logic                elem_int8;
    logic [AWIDTH-1:0]   address_mat_a;
    logic [AWIDTH-1:0]   address_mat_b;
    logic [AWIDTH-1:0]   address_mat_c;
    logic [STRIDE_W-1:0] address_stride_a;
    logic [STRIDE_W-1:0] address_stride_b;
    logic [STRIDE_W-1:0] address_stride_c;

    logic                mem_apb_rd_en;
    logic                mem_apb_wr_en;
    logic [AWIDTH-1:0]   mem_apb_addr;
    logic [WORD_W-1:0]   mem_apb_wdata;

    logic                eng_rd_en;
    logic [AWIDTH-1:0]   rd_a_addr;
    logic [AWIDTH-1:0]   rd_b_addr;
    logic [WORD_W-1:0]   rd_a_data;
    logic [WORD_W-1:0]   rd_b_data;
    logic                first;
    logic                last;

    logic                result_valid;
    elem16_t             result;
    logic                saturated;

    logic                eng_wr_en;
    logic [AWIDTH-1:0]   wr_addr;
    logic [WORD_W-1:0]   wr_data;
    logic                done_pulse;
    logic                sat_pulse;

    apb_csr_slave u_csr (
        .PCLK             (PCLK),
        .PRESETn          (PRESETn),
        .PADDR            (PADDR),
        .PWRITE           (PWRITE),
        .PSEL             (PSEL),
        .PENABLE          (PENABLE),
        .PWDATA           (PWDATA),
        .PRDATA           (PRDATA),
        .PREADY           (PREADY),
        .start            (start),
        .elem_int8        (elem_int8),
        .address_mat_a    (address_mat_a),
        .address_mat_b    (address_mat_b),
        .address_mat_c    (address_mat_c),
        .address_stride_a (address_stride_a),
        .address_stride_b (address_stride_b),
        .address_stride_c (address_stride_c),
        .done_pulse       (done_pulse),
        .sat_pulse        (sat_pulse),
        .mem_apb_rd_en    (mem_apb_rd_en),
        .mem_apb_wr_en    (mem_apb_wr_en),
        .mem_apb_addr     (mem_apb_addr),
        .mem_apb_wdata    (mem_apb_wdata),
        .mem_rdata        (rd_a_data)
    );

    operand_fetch #(
        .DIM (DIM)
    ) u_fetch (
        .PCLK             (PCLK),
        .PRESETn          (PRESETn),
        .start            (start),
        .address_mat_a    (address_mat_a),
        .address_mat_b    (address_mat_b),
        .address_stride_a (address_stride_a),
        .address_stride_b (address_stride_b),
        .eng_rd_en        (eng_rd_en),
        .rd_a_addr        (rd_a_addr),
        .rd_b_addr        (rd_b_addr),
        .first            (first),
        .last             (last)
    );

    mac_unit u_mac (
        .PCLK         (PCLK),
        .PRESETn      (PRESETn),
        .elem_int8    (elem_int8),
        .valid        (eng_rd_en),
        .first        (first),
        .last         (last),
        .a_word       (rd_a_data),
        .b_word       (rd_b_data),
        .result_valid (result_valid),
        .result       (result),
        .saturated    (saturated)
    );

    result_writer #(
        .DIM (DIM)
    ) u_writer (
        .PCLK             (PCLK),
        .PRESETn          (PRESETn),
        .start            (start),
        .address_mat_c    (address_mat_c),
        .address_stride_c (address_stride_c),
        .result_valid     (result_valid),
        .result           (result),
        .saturated        (saturated),
        .eng_wr_en        (eng_wr_en),
        .wr_addr          (wr_addr),
        .wr_data          (wr_data),
        .done_pulse       (done_pulse),
        .sat_pulse        (sat_pulse)
    );

    scratch_ram u_ram (
        .PCLK          (PCLK),
        .mem_apb_rd_en (mem_apb_rd_en),
        .mem_apb_wr_en (mem_apb_wr_en),
        .mem_apb_addr  (mem_apb_addr),
        .mem_apb_wdata (mem_apb_wdata),
        .eng_rd_en     (eng_rd_en),
        .rd_a_addr     (rd_a_addr),
        .rd_b_addr     (rd_b_addr),
        .eng_wr_en     (eng_wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .rd_a_data     (rd_a_data),
        .rd_b_data     (rd_b_data)
    );

endmodule

// ==== verilog/scratch_ram.sv ====
`timescale 1ns/1ps

module scratch_ram (
    input  logic                               PCLK,
    input  logic                               mem_apb_rd_en,
    input  logic                               mem_apb_wr_en,
    input  logic [matmul_csr_pkg::AWIDTH-1:0]  mem_apb_addr,
    input  logic [matmul_data_pkg::WORD_W-1:0] mem_apb_wdata,
    input  logic                               eng_rd_en,
    input  logic [matmul_csr_pkg::AWIDTH-1:0]  rd_a_addr,
    input  logic [matmul_csr_pkg::AWIDTH-1:0]  rd_b_addr,
    input  logic                               eng_wr_en,
    input  logic [matmul_csr_pkg::AWIDTH-1:0]  wr_addr,
    input  logic [matmul_data_pkg::WORD_W-1:0] wr_data,
    output logic [matmul_data_pkg::WORD_W-1:0] rd_a_data,
    output logic [matmul_data_pkg::WORD_W-1:0] rd_b_data
);
    import matmul_csr_pkg::*;
    import matmul_data_pkg::*;

    localparam int DEPTH = 1 << AWIDTH;

    logic [WORD_W-1:0] mem [DEPTH];

    // Engine ports win, APB only gets the RAM when idle
    always_ff @(posedge PCLK) begin
        if (eng_wr_en) begin
            mem[wr_addr] <= wr_data;
        end else if (mem_apb_wr_en) begin
            mem[mem_apb_addr] <= mem_apb_wdata;
        end
        if (eng_rd_en) begin
            rd_a_data <= mem[rd_a_addr];
            rd_b_data <= mem[rd_b_addr];
        end else if (mem_apb_rd_en) begin
            rd_a_data <= mem[mem_apb_addr];
        end
    end

endmodule

// ==== verilog/result_writer.sv ====
`timescale 1ns/1ps

module result_writer #(
    parameter int DIM = 4
) (
    input  logic                                PCLK,
    input  logic                                PRESETn,
    input  logic                                start,
    input  logic [matmul_csr_pkg::AWIDTH-1:0]   address_mat_c,
    input  logic [matmul_csr_pkg::STRIDE_W-1:0] address_stride_c,
    input  logic                                result_valid,
    input  matmul_data_pkg::elem16_t            result,
    input  logic                                saturated,
    output logic                                eng_wr_en,
    output logic [matmul_csr_pkg::AWIDTH-1:0]   wr_addr,
    output logic [matmul_data_pkg::WORD_W-1:0]  wr_data,
    output logic                                done_pulse,
    output logic                                sat_pulse
);
    import matmul_csr_pkg::*;

    localparam int            CW   = $clog2(DIM);
    localparam logic [CW-1:0] LAST = CW'(DIM - 1);

    logic [CW-1:0] i;
    logic [CW-1:0] j;
    logic          wr_last;

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            i          <= '0;
            j          <= '0;
            eng_wr_en  <= 1'b0;
            sat_pulse  <= 1'b0;
            wr_last    <= 1'b0;
            done_pulse <= 1'b0;
        end else begin
            eng_wr_en  <= result_valid;
            sat_pulse  <= result_valid && saturated;
            wr_last    <= result_valid && (i == LAST) && (j == LAST);
            // One cycle after the final C write
            done_pulse <= wr_last;
            if (start) begin
                i <= '0;
                j <= '0;
            end else if (result_valid) begin
                j <= (j == LAST) ? '0 : j + 1'b1;
                if (j == LAST) begin
                    i <= (i == LAST) ? '0 : i + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge PCLK) begin
        if (result_valid) begin
            wr_addr <= address_mat_c + AWIDTH'(i) * AWIDTH'(address_stride_c) + AWIDTH'(j);
            wr_data <= result;
        end
    end

endmodule

// ==== verilog/mac_unit.sv ====
`timescale 1ns/1ps

module mac_unit (
    input  logic                               PCLK,
    input  logic                               PRESETn,
    input  logic                               elem_int8,
    input  logic                               valid,
    input  logic                               first,
    input  logic                               last,
    input  logic [matmul_data_pkg::WORD_W-1:0] a_word,
    input  logic [matmul_data_pkg::WORD_W-1:0] b_word,
    output logic                               result_valid,
    output matmul_data_pkg::elem16_t           result,
    output logic                               saturated
);
    import matmul_data_pkg::*;

    localparam elem16_t E16_MAX = 16'sh7fff;
    localparam elem16_t E16_MIN = 16'sh8000;

    operand_word_u a_u;
    operand_word_u b_u;
    acc_t          acc;
    acc_t          prod;
    acc_t          sum;
    logic          data_valid;
    logic          over;
    logic          under;

    assign a_u = a_word;
    assign b_u = b_word;

    always_comb begin
        if (elem_int8) begin
            // Both lanes belong to the same dot product
            prod = acc_t'(a_u.e8.hi) * acc_t'(b_u.e8.hi)
                 + acc_t'(a_u.e8.lo) * acc_t'(b_u.e8.lo);
        end else begin
            prod = acc_t'(a_u.e16) * acc_t'(b_u.e16);
        end
        sum   = (first ? '0 : acc) + prod;
        over  = sum > acc_t'(E16_MAX);
        under = sum < acc_t'(E16_MIN);
    end

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            data_valid   <= 1'b0;
            result_valid <= 1'b0;
            saturated    <= 1'b0;
        end else begin
            // Read data lags the address strobe by one cycle
            data_valid   <= valid;
            result_valid <= data_valid && last;
            if (data_valid && last) begin
                saturated <= over || under;
            end
        end
    end

    always_ff @(posedge PCLK) begin
        if (data_valid) begin
            acc <= sum;
        end
        if (data_valid && last) begin
            result <= over ? E16_MAX : (under ? E16_MIN : sum[15:0]);
        end
    end

endmodule

// ==== verilog/operand_fetch.sv ====
`timescale 1ns/1ps

module operand_fetch #(
    parameter int DIM = 4
) (
    input  logic                                PCLK,
    input  logic                                PRESETn,
    input  logic                                start,
    input  logic [matmul_csr_pkg::AWIDTH-1:0]   address_mat_a,
    input  logic [matmul_csr_pkg::AWIDTH-1:0]   address_mat_b,
    input  logic [matmul_csr_pkg::STRIDE_W-1:0] address_stride_a,
    input  logic [matmul_csr_pkg::STRIDE_W-1:0] address_stride_b,
    output logic                                eng_rd_en,
    output logic [matmul_csr_pkg::AWIDTH-1:0]   rd_a_addr,
    output logic [matmul_csr_pkg::AWIDTH-1:0]   rd_b_addr,
    output logic                                first,
    output logic                                last
);
    import matmul_csr_pkg::*;

    localparam int            CW   = $clog2(DIM);
    localparam logic [CW-1:0] LAST = CW'(DIM - 1);

    logic          running;
    logic [CW-1:0] i;
    logic [CW-1:0] j;
    logic [CW-1:0] k;

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            running <= 1'b0;
            i       <= '0;
            j       <= '0;
            k       <= '0;
            first   <= 1'b0;
            last    <= 1'b0;
        end else begin
            // Marks line up with the read data one cycle on
            first <= running && (k == '0);
            last  <= running && (k == LAST);
            if (start) begin
                running <= 1'b1;
                i       <= '0;
                j       <= '0;
                k       <= '0;
            end else if (running) begin
                if (k != LAST) begin
                    k <= k + 1'b1;
                end else begin
                    k <= '0;
                    if (j != LAST) begin
                        j <= j + 1'b1;
                    end else begin
                        j <= '0;
                        i <= (i == LAST) ? '0 : i + 1'b1;
                        running <= (i != LAST);
                    end
                end
            end
        end
    end

    assign eng_rd_en = running;
    // A walks a row, B walks a column
    assign rd_a_addr = address_mat_a + AWIDTH'(i) * AWIDTH'(address_stride_a) + AWIDTH'(k);
    assign rd_b_addr = address_mat_b + AWIDTH'(k) * AWIDTH'(address_stride_b) + AWIDTH'(j);

endmodule

// ==== verilog/apb_csr_slave.sv ====
`timescale 1ns/1ps

module apb_csr_slave (
    input  logic                                  PCLK,
    input  logic                                  PRESETn,
    input  logic [matmul_csr_pkg::APB_ADDR_W-1:0] PADDR,
    input  logic                                  PWRITE,
    input  logic                                  PSEL,
    input  logic                                  PENABLE,
    input  logic [matmul_csr_pkg::APB_DATA_W-1:0] PWDATA,
    output logic [matmul_csr_pkg::APB_DATA_W-1:0] PRDATA,
    output logic                                  PREADY,

    output logic                                  start,
    output logic                                  elem_int8,
    output logic [matmul_csr_pkg::AWIDTH-1:0]     address_mat_a,
    output logic [matmul_csr_pkg::AWIDTH-1:0]     address_mat_b,
    output logic [matmul_csr_pkg::AWIDTH-1:0]     address_mat_c,
    output logic [matmul_csr_pkg::STRIDE_W-1:0]   address_stride_a,
    output logic [matmul_csr_pkg::STRIDE_W-1:0]   address_stride_b,
    output logic [matmul_csr_pkg::STRIDE_W-1:0]   address_stride_c,

    input  logic                                  done_pulse,
    input  logic                                  sat_pulse,

    output logic                                  mem_apb_rd_en,
    output logic                                  mem_apb_wr_en,
    output logic [matmul_csr_pkg::AWIDTH-1:0]     mem_apb_addr,
    output logic [matmul_data_pkg::WORD_W-1:0]    mem_apb_wdata,
    input  logic [matmul_data_pkg::WORD_W-1:0]    mem_rdata
);
    import matmul_csr_pkg::*;
    import matmul_data_pkg::*;

    localparam logic [1:0] IDLE         = 2'b00;
    localparam logic [1:0] SETUP        = 2'b01;
    localparam logic [1:0] READ_ACCESS  = 2'b10;
    localparam logic [1:0] WRITE_ACCESS = 2'b11;

    logic [1:0]            state;
    logic [1:0]            next_state;
    logic                  busy;
    logic                  done;
    logic [FLAG_W-1:0]     flags;
    logic                  win;
    logic                  acc_write;
    logic                  csr_write;
    logic                  rd_load;
    logic                  win_rd;
    logic [APB_DATA_W-1:0] csr_rdata;

    assign PREADY = 1'b1;

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (PSEL && !PENABLE) begin
                    next_state = SETUP;
                end
            end
            SETUP: begin
                if (PSEL && PENABLE) begin
                    next_state = PWRITE ? WRITE_ACCESS : READ_ACCESS;
                end else begin
                    next_state = IDLE;
                end
            end
            default: begin
                // Back-to-back transfer goes straight to setup
                if (PSEL && !PENABLE) begin
                    next_state = SETUP;
                end else if (!PSEL) begin
                    next_state = IDLE;
                end
            end
        endcase
    end

    assign win       = PADDR[APB_ADDR_W-1];
    assign acc_write = (state == SETUP) && PSEL && PENABLE && PWRITE;
    assign csr_write = acc_write && !win;
    assign rd_load   = (next_state == SETUP) && !PWRITE;

    // Scratchpad window, closed while the engine runs
    assign mem_apb_rd_en = rd_load && win && !busy;
    assign mem_apb_wr_en = acc_write && win && !busy;
    assign mem_apb_addr  = PADDR[AWIDTH-1:0];
    assign mem_apb_wdata = PWDATA[WORD_W-1:0];

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            start            <= 1'b0;
            busy             <= 1'b0;
            done             <= 1'b0;
            flags            <= '0;
            elem_int8        <= 1'b0;
            address_mat_a    <= '0;
            address_mat_b    <= '0;
            address_mat_c    <= '0;
            address_stride_a <= '0;
            address_stride_b <= '0;
            address_stride_c <= '0;
        end else begin
            start <= 1'b0;
            if (done_pulse) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
            if (sat_pulse) begin
                flags[FLAG_SAT] <= 1'b1;
            end
            if (csr_write) begin
                case (PADDR)
                    ADDR_START: begin
                        if (PWDATA[0] && busy) begin
                            flags[FLAG_START_BUSY] <= 1'b1;
                        end else if (PWDATA[0]) begin
                            start <= 1'b1;
                            busy  <= 1'b1;
                            done  <= 1'b0;
                            flags <= '0;
                        end
                    end
                    ADDR_ELEM_INT8: elem_int8        <= PWDATA[0];
                    ADDR_MAT_A:     address_mat_a    <= PWDATA[AWIDTH-1:0];
                    ADDR_MAT_B:     address_mat_b    <= PWDATA[AWIDTH-1:0];
                    ADDR_MAT_C:     address_mat_c    <= PWDATA[AWIDTH-1:0];
                    ADDR_STRIDE_A:  address_stride_a <= PWDATA[STRIDE_W-1:0];
                    ADDR_STRIDE_B:  address_stride_b <= PWDATA[STRIDE_W-1:0];
                    ADDR_STRIDE_C:  address_stride_c <= PWDATA[STRIDE_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Loaded at the end of setup, window addresses fall to zero here
    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            csr_rdata <= '0;
            win_rd    <= 1'b0;
        end else if (rd_load) begin
            win_rd <= win && !busy;
            case (PADDR)
                ADDR_START:     csr_rdata <= APB_DATA_W'(start);
                ADDR_ELEM_INT8: csr_rdata <= APB_DATA_W'(elem_int8);
                ADDR_MAT_A:     csr_rdata <= APB_DATA_W'(address_mat_a);
                ADDR_MAT_B:     csr_rdata <= APB_DATA_W'(address_mat_b);
                ADDR_MAT_C:     csr_rdata <= APB_DATA_W'(address_mat_c);
                ADDR_STRIDE_A:  csr_rdata <= APB_DATA_W'(address_stride_a);
                ADDR_STRIDE_B:  csr_rdata <= APB_DATA_W'(address_stride_b);
                ADDR_STRIDE_C:  csr_rdata <= APB_DATA_W'(address_stride_c);
                ADDR_STATUS:    csr_rdata <= APB_DATA_W'({busy, flags, done});
                default:        csr_rdata <= '0;
            endcase
        end
    end

    // RAM word arrives at the same edge, so it bypasses the register
    assign PRDATA = win_rd ? APB_DATA_W'(mem_rdata) : csr_rdata;

endmodule

// ==== verilog/matmul_data_pkg.sv ====
package matmul_data_pkg;

    localparam int WORD_W = 16;

    typedef logic signed [15:0] elem16_t;
    typedef logic signed [7:0]  elem8_t;
    typedef logic signed [31:0] acc_t;

    // Two int8 lanes, both along K
    typedef struct packed {
        elem8_t hi;
        elem8_t lo;
    } elem8_pair_t;

    // One scratchpad word, int16 or packed int8 pair
    typedef union packed {
        elem16_t     e16;
        elem8_pair_t e8;
    } operand_word_u;

endpackage

// ==== verilog/matmul_csr_pkg.sv ====
package matmul_csr_pkg;

    // APB side, bit 8 of the address selects the memory window
    localparam int APB_ADDR_W = 9;
    localparam int APB_DATA_W = 32;

    localparam int AWIDTH   = 8;
    localparam int STRIDE_W = 8;

    // CSR offsets
    localparam logic [APB_ADDR_W-1:0] ADDR_START     = APB_ADDR_W'(0);
    localparam logic [APB_ADDR_W-1:0] ADDR_MAT_A     = APB_ADDR_W'(1);
    localparam logic [APB_ADDR_W-1:0] ADDR_MAT_B     = APB_ADDR_W'(2);
    localparam logic [APB_ADDR_W-1:0] ADDR_MAT_C     = APB_ADDR_W'(3);
    localparam logic [APB_ADDR_W-1:0] ADDR_STRIDE_A  = APB_ADDR_W'(4);
    localparam logic [APB_ADDR_W-1:0] ADDR_STRIDE_B  = APB_ADDR_W'(5);
    localparam logic [APB_ADDR_W-1:0] ADDR_STRIDE_C  = APB_ADDR_W'(6);
    localparam logic [APB_ADDR_W-1:0] ADDR_STATUS    = APB_ADDR_W'(7);
    localparam logic [APB_ADDR_W-1:0] ADDR_ELEM_INT8 = APB_ADDR_W'(8);

    // Sticky flags in STATUS
    localparam int FLAG_W          = 2;
    localparam int FLAG_SAT        = 0;
    localparam int FLAG_START_BUSY = 1;

endpackage
